//--- Bender.yml
package:
  name: dwnld_sys

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/dwnld_pkg.sv
      - hdl/dwnld_bank_map.sv
      - hdl/dwnld_prog_fmt.sv
      - hdl/dwnld_prom.sv
      - hdl/dwnld_ctrl.sv
      - hdl/dwnld_top.sv
  - target: test
    files:
      - test/dwnld_clkgen.sv
      - test/dwnld_assertions.sv
      - test/dwnld_tb.sv

//--- dwnld_sys.f
+incdir+include
hdl/dwnld_pkg.sv
hdl/dwnld_bank_map.sv
hdl/dwnld_prog_fmt.sv
hdl/dwnld_prom.sv
hdl/dwnld_ctrl.sv
hdl/dwnld_top.sv
test/dwnld_clkgen.sv
test/dwnld_assertions.sv
test/dwnld_tb.sv

//--- hdl/dwnld_bank_map.sv
/*
 * Download address decoder
 * splits a loader byte address into PROM region or SDRAM bank plus offset
 */

`default_nettype none

module dwnld_bank_map import dwnld_pkg::*; (
    input  wire logic [DWNLD_AW-1:0] ioctl_addr,
    input  wire logic [7:0]          ioctl_data,
    output dwnld_byte_t              decoded
);

    // start of the region the address falls in
    logic [DWNLD_AW-1:0] base;
    // byte offset from that start
    logic [DWNLD_AW-1:0] offset;
    logic [1:0]          bank;
    logic                is_prom;

    ///////////////////////////////////////////////////////////////////////
    // region and bank selection

    // the regions are checked from the top of the map down
    // so each compare only needs a lower bound
    always_comb begin
        is_prom = 1'b0;
        bank    = 2'd0;
        base    = '0;
        if (ioctl_addr >= PROM_START) begin
            // PROM bytes carry bank 0, the bank is not looked at for them
            is_prom = 1'b1;
            base    = PROM_START;
        end else if (ioctl_addr >= BA3_START) begin
            bank = 2'd3;
            base = BA3_START;
        end else if (ioctl_addr >= BA2_START) begin
            bank = 2'd2;
            base = BA2_START;
        end else if (ioctl_addr >= BA1_START) begin
            bank = 2'd1;
            base = BA1_START;
        end
    end

    assign offset = ioctl_addr - base;

    ///////////////////////////////////////////////////////////////////////
    // decoded byte

    always_comb begin
        decoded         = '0;
        decoded.is_prom = is_prom;
        decoded.bank    = bank;
        decoded.odd     = ioctl_addr[0];
        decoded.data    = ioctl_data;
        if (is_prom) begin
            decoded.dest.prom.idx = offset[PROM_AW-1:0];
        end else begin
            // two bytes per SDRAM word, so drop the byte select bit
            decoded.dest.sdram = offset[PROG_AW:1];
        end
    end

endmodule

`default_nettype wire

//--- hdl/dwnld_ctrl.sv
/*
 * Download control
 * routes loader strobes to SDRAM or PROM, holds the SDRAM request until ack,
 * and flags the end of a download
 */

`default_nettype none

module dwnld_ctrl (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic downloading,
    input  wire logic ioctl_wr,
    input  wire logic is_prom,
    input  wire logic sdram_ack,
    output logic      load,
    output logic      prog_we,
    output logic      prom_we,
    output logic      dwnld_done
);

    // a strobe only counts while the download level is high
    logic accept;
    // download level seen on the previous cycle
    logic dl_prev;

    ///////////////////////////////////////////////////////////////////////
    // strobe qualification

    assign accept = ioctl_wr && downloading;

    // load goes straight to the formatter register
    // so the port is valid on the cycle after the strobe
    assign load = accept && !is_prom;

    ///////////////////////////////////////////////////////////////////////
    // SDRAM write request

    // a new byte while the request is pending simply reloads the port
    // and the request stays up, the loader is expected to pace itself
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
        end else if (load) begin
            prog_we <= 1'b1;
        end else if (sdram_ack || !downloading) begin
            // dropped on the cycle after the ack, or when the download is cut
            prog_we <= 1'b0;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // PROM write pulse

    // one pulse per PROM byte, in step with the PROM's own input register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prom_we <= 1'b0;
        end else begin
            prom_we <= accept && is_prom;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // end of download

    // falling edge of the download level gives a single done pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dl_prev    <= 1'b0;
            dwnld_done <= 1'b0;
        end else begin
            dl_prev    <= downloading;
            dwnld_done <= dl_prev && !downloading;
        end
    end

endmodule

`default_nettype wire

//--- hdl/dwnld_pkg.sv
/*
 * ROM download package
 * address map, widths and the types passed between the download blocks
 */

`default_nettype none

package dwnld_pkg;

    `include "dwnld_defs.svh"

    ///////////////////////////////////////////////////////////////////////
    // address map

    localparam int unsigned DWNLD_AW = `DWNLD_AW;
    localparam int unsigned PROG_AW  = 22;
    // 1024 bytes of PROM
    localparam int unsigned PROM_AW  = 10;

    localparam logic [DWNLD_AW-1:0] BA1_START  = `DWNLD_BA1_START;
    localparam logic [DWNLD_AW-1:0] BA2_START  = `DWNLD_BA2_START;
    localparam logic [DWNLD_AW-1:0] BA3_START  = `DWNLD_BA3_START;
    localparam logic [DWNLD_AW-1:0] PROM_START = `DWNLD_PROM_START;

    ///////////////////////////////////////////////////////////////////////
    // types

    // the same destination word is an SDRAM word address or a PROM byte index
    typedef union packed {
        logic [PROG_AW-1:0] sdram;
        struct packed {
            logic [PROG_AW-PROM_AW-1:0] pad;
            logic [PROM_AW-1:0]         idx;
        } prom;
    } dwnld_dest_u;

    // one byte of the stream after address decoding
    typedef struct packed {
        logic        is_prom;
        logic [1:0]  bank;
        dwnld_dest_u dest;
        logic        odd;
        logic [7:0]  data;
    } dwnld_byte_t;

    // SDRAM programming port, mask is active low with bit 1 for data[15:8]
    typedef struct packed {
        logic [PROG_AW-1:0] addr;
        logic [15:0]        data;
        logic [1:0]         mask;
        logic [1:0]         ba;
    } prog_port_t;

endpackage

`default_nettype wire

//--- hdl/dwnld_prog_fmt.sv
/*
 * SDRAM programming port formatter
 * registers word address, bank, byte mask and duplicated data for each SDRAM byte
 */

`default_nettype none

module dwnld_prog_fmt import dwnld_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        load,
    input  wire dwnld_byte_t decoded,
    output prog_port_t       prog
);

    // next value of the port, built from the current decode
    prog_port_t prog_nxt;

    ///////////////////////////////////////////////////////////////////////
    // word formatting

    always_comb begin
        prog_nxt.addr = decoded.dest.sdram;
        prog_nxt.ba   = decoded.bank;
        // the byte is placed on both halves
        // the SDRAM side picks the half through the mask
        prog_nxt.data = {2{decoded.data}};
        // active low mask with bit 1 for the upper half
        // odd bytes land in the upper half, even bytes in the lower
        if (decoded.odd) begin
            prog_nxt.mask = 2'b01;
        end else begin
            prog_nxt.mask = 2'b10;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // output register

    // load only comes for accepted SDRAM bytes
    // so PROM bytes and idle cycles leave the port alone
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prog <= '0;
        end else if (load) begin
            prog <= prog_nxt;
        end
    end

endmodule

`default_nettype wire

//--- hdl/dwnld_prom.sv
/*
 * On-chip PROM filled by the download
 * synchronous write from the byte stream, registered read port for the game
 */

`default_nettype none

module dwnld_prom import dwnld_pkg::*; (
    input  wire logic               clk,
    input  wire logic               prom_we,
    input  wire dwnld_byte_t        decoded,
    input  wire logic [PROM_AW-1:0] prom_rd_addr,
    output logic [7:0]              prom_rd_data
);

    logic [7:0]         mem [0:(2**PROM_AW)-1];
    // write index and data delayed by one cycle to line up with prom_we
    logic [PROM_AW-1:0] wr_idx;
    logic [7:0]         wr_data;

    ///////////////////////////////////////////////////////////////////////
    // write side

    // capture every cycle, only the cycle of an accepted PROM byte matters
    // because prom_we follows exactly one cycle later
    always_ff @(posedge clk) begin
        wr_idx  <= decoded.dest.prom.idx;
        wr_data <= decoded.data;
    end

    always_ff @(posedge clk) begin
        if (prom_we) begin
            mem[wr_idx] <= wr_data;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // read side

    // one cycle of latency from address to data
    always_ff @(posedge clk) begin
        prom_rd_data <= mem[prom_rd_addr];
    end

endmodule

`default_nettype wire

//--- hdl/dwnld_top.sv
/*
 * ROM download path top level
 * loader byte stream to SDRAM programming port and on-chip PROM
 */

`default_nettype none

module dwnld_top import dwnld_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst_n,
    // loader side
    input  wire logic                downloading,
    input  wire logic [DWNLD_AW-1:0] ioctl_addr,
    input  wire logic [7:0]          ioctl_data,
    input  wire logic                ioctl_wr,
    // SDRAM programming port
    input  wire logic                sdram_ack,
    output prog_port_t               prog,
    output logic                     prog_we,
    // game read port of the PROM
    input  wire logic [PROM_AW-1:0]  prom_rd_addr,
    output logic [7:0]               prom_rd_data,
    output logic                     dwnld_done
);

    dwnld_byte_t decoded;
    logic        load;
    logic        prom_we;

    dwnld_ctrl i_dwnld_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_wr    (ioctl_wr),
        .is_prom     (decoded.is_prom),
        .sdram_ack   (sdram_ack),
        .load        (load),
        .prog_we     (prog_we),
        .prom_we     (prom_we),
        .dwnld_done  (dwnld_done)
    );

    // combinational decode of the byte currently on the loader bus
    dwnld_bank_map i_dwnld_bank_map (
        .ioctl_addr (ioctl_addr),
        .ioctl_data (ioctl_data),
        .decoded    (decoded)
    );

    dwnld_prog_fmt i_dwnld_prog_fmt (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .decoded (decoded),
        .prog    (prog)
    );

    dwnld_prom i_dwnld_prom (
        .clk          (clk),
        .prom_we      (prom_we),
        .decoded      (decoded),
        .prom_rd_addr (prom_rd_addr),
        .prom_rd_data (prom_rd_data)
    );

endmodule

`default_nettype wire

//--- include/dwnld_defs.svh
/*
 * ROM download address map shared by the download path
 * byte addresses of the bank starts and of the PROM region in the loader stream
 */

`ifndef DWNLD_DEFS_SVH
`define DWNLD_DEFS_SVH

// width of the byte address coming from the loader
`define DWNLD_AW        25

// bank 0 always starts at byte zero, so only banks 1 to 3 need a start
`define DWNLD_BA1_START 25'h010_0000
`define DWNLD_BA2_START 25'h020_0000
`define DWNLD_BA3_START 25'h030_0000

// everything from here upwards goes to the on-chip PROM and not to SDRAM
// the PROM must sit above the last bank start
`define DWNLD_PROM_START 25'h040_0000

`endif

//--- test/dwnld_assertions.sv
/*
 * Protocol checks for the ROM download path
 * bound into dwnld_top, covers the request, PROM pulse and done timing
 */

`default_nettype none

module dwnld_assertions import dwnld_pkg::*; (
    input wire logic                clk,
    input wire logic                rst_n,
    input wire logic                downloading,
    input wire logic [DWNLD_AW-1:0] ioctl_addr,
    input wire logic                ioctl_wr,
    input wire logic                sdram_ack,
    input wire logic                load,
    input wire logic                prom_we,
    input wire prog_port_t          prog,
    input wire logic                prog_we,
    input wire logic                dwnld_done
);

    // failed checks, collected by the testbench at the end of the run
    int unsigned fail_count = 0;

    ///////////////////////////////////////////////////////////////////////
    // reset

    // the first sampled cycle out of reset must see every output idle
    a_reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> !prog_we && !prom_we && !load && !dwnld_done && prog == '0)
    else begin
        fail_count++;
        $error("control outputs not idle when reset is released");
    end

    ///////////////////////////////////////////////////////////////////////
    // SDRAM request

    // every SDRAM byte raises the request, and a reload keeps it up
    a_load_req: assert property (@(posedge clk) disable iff (!rst_n)
        load |=> prog_we)
    else begin
        fail_count++;
        $error("prog_we not high after an SDRAM byte");
    end

    a_ack_drop: assert property (@(posedge clk) disable iff (!rst_n)
        prog_we && sdram_ack && !load |=> !prog_we)
    else begin
        fail_count++;
        $error("prog_we still high after sdram_ack");
    end

    // the end of a download kills a request that is still pending
    a_cut_drop: assert property (@(posedge clk) disable iff (!rst_n)
        !downloading |=> !prog_we)
    else begin
        fail_count++;
        $error("prog_we high while not downloading");
    end

    a_no_stray_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(prog_we) |-> $past(load))
    else begin
        fail_count++;
        $error("prog_we rose without an SDRAM byte");
    end

    ///////////////////////////////////////////////////////////////////////
    // PROM pulse and end of download

    // each accepted byte at or above the PROM start gives one write pulse a cycle later
    a_prom_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        prom_we == $past(ioctl_wr && downloading && (ioctl_addr >= PROM_START)))
    else begin
        fail_count++;
        $error("prom_we does not follow the accepted PROM bytes");
    end

    a_done_after_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(downloading) |=> dwnld_done)
    else begin
        fail_count++;
        $error("no dwnld_done pulse after the download ended");
    end

    a_done_only_after_fall: assert property (@(posedge clk) disable iff (!rst_n)
        dwnld_done |-> $past(downloading, 2) && !$past(downloading))
    else begin
        fail_count++;
        $error("dwnld_done pulsed without a fall of downloading");
    end

endmodule

`default_nettype wire

//--- test/dwnld_clkgen.sv
/*
 * Testbench clock and reset generator
 */

`default_nettype none

module dwnld_clkgen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset leaves on a falling edge, like every other input
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- test/dwnld_tb.sv
/*
 * ROM download path testbench
 * random SDRAM and PROM bytes checked against a reference address model
 */

`default_nettype none

module dwnld_tb import dwnld_pkg::*; ();

    localparam int N_SDRAM   = 64;
    localparam int N_PROM    = 64;
    // longest SDRAM byte is write, 7 cycles of ack delay and the ack itself
    localparam int SDRAM_CYC = 12;
    localparam int PROM_CYC  = 4;
    localparam int TIMEOUT   = (N_SDRAM * SDRAM_CYC + N_PROM * PROM_CYC + 200) * 10;

    logic                clk;
    logic                rst_n;
    logic                downloading;
    logic [DWNLD_AW-1:0] ioctl_addr;
    logic [7:0]          ioctl_data;
    logic                ioctl_wr;
    logic                sdram_ack;
    logic [PROM_AW-1:0]  prom_rd_addr;
    prog_port_t          prog;
    logic                prog_we;
    logic [7:0]          prom_rd_data;
    logic                dwnld_done;

    logic [15:0]         lfsr_state = 16'd15;
    int unsigned         errors     = 0;
    int unsigned         done_count = 0;
    int unsigned         a_fails;
    // bytes written into the PROM and the indexes that hold them
    logic [7:0]          prom_model [0:(2**PROM_AW)-1];
    logic [PROM_AW-1:0]  prom_idx [$];

    dwnld_clkgen i_dwnld_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    dwnld_top i_dwnld_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .downloading  (downloading),
        .ioctl_addr   (ioctl_addr),
        .ioctl_data   (ioctl_data),
        .ioctl_wr     (ioctl_wr),
        .sdram_ack    (sdram_ack),
        .prog         (prog),
        .prog_we      (prog_we),
        .prom_rd_addr (prom_rd_addr),
        .prom_rd_data (prom_rd_data),
        .dwnld_done   (dwnld_done)
    );

    bind dwnld_top dwnld_assertions i_assertions (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_wr    (ioctl_wr),
        .sdram_ack   (sdram_ack),
        .load        (load),
        .prom_we     (prom_we),
        .prog        (prog),
        .prog_we     (prog_we),
        .dwnld_done  (dwnld_done)
    );

    ///////////////////////////////////////////////////////////////////////
    // random source and reference model

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // port contents for one SDRAM byte, straight from the address map
    function automatic prog_port_t expected_prog(input logic [DWNLD_AW-1:0] addr,
                                                 input logic [7:0] data);
        prog_port_t          p;
        logic [DWNLD_AW-1:0] rel;
        p.ba = 2'd0;
        rel  = addr;
        if (addr >= BA3_START) begin
            p.ba = 2'd3;
            rel  = addr - BA3_START;
        end else if (addr >= BA2_START) begin
            p.ba = 2'd2;
            rel  = addr - BA2_START;
        end else if (addr >= BA1_START) begin
            p.ba = 2'd1;
            rel  = addr - BA1_START;
        end
        p.addr = PROG_AW'(rel >> 1);
        p.data = {data, data};
        // active low, an odd byte writes the upper half only
        p.mask = addr[0] ? 2'b01 : 2'b10;
        return p;
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // stimulus and checks, all called on a falling edge

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        assert (got == exp) else begin
            errors++;
            $display("MISMATCH @%0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // one cycle strobe, returns on the edge where the result is visible
    task automatic drive_byte(input logic [DWNLD_AW-1:0] addr, input logic [7:0] data);
        ioctl_addr = addr;
        ioctl_data = data;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
    endtask

    task automatic acknowledge();
        sdram_ack = 1'b1;
        @(negedge clk);
        sdram_ack = 1'b0;
        check_value(64'(prog_we), 64'(1'b0), "prog_we after ack");
    endtask

    task automatic send_sdram_byte(input logic [1:0] bank);
        logic [19:0]         offset;
        logic [7:0]          data;
        logic [DWNLD_AW-1:0] addr;
        int                  delay;
        offset = 20'(rand_bits(20));
        data   = 8'(rand_bits(8));
        addr   = {3'b000, bank, offset};
        delay  = int'(rand_bits(3));
        drive_byte(addr, data);
        check_value(64'(prog), 64'(expected_prog(addr, data)), "prog");
        check_value(64'(prog_we), 64'(1'b1), "prog_we");
        repeat (delay) begin
            @(negedge clk);
            check_value(64'(prog_we), 64'(1'b1), "prog_we before ack");
        end
        acknowledge();
    endtask

    // a second byte before the ack takes over the pending request
    task automatic reload_pending();
        logic [DWNLD_AW-1:0] addr;
        logic [7:0]          data;
        drive_byte({3'b000, 2'd1, 20'(rand_bits(20))}, 8'(rand_bits(8)));
        addr = {3'b000, 2'd2, 20'(rand_bits(20))};
        data = 8'(rand_bits(8));
        drive_byte(addr, data);
        check_value(64'(prog), 64'(expected_prog(addr, data)), "prog after reload");
        check_value(64'(prog_we), 64'(1'b1), "prog_we after reload");
        acknowledge();
    endtask

    task automatic read_prom_check(input logic [PROM_AW-1:0] idx);
        prom_rd_addr = idx;
        @(negedge clk);
        check_value(64'(prom_rd_data), 64'(prom_model[idx]), "prom_rd_data");
    endtask

    // PROM bytes go to unique indexes, one per 16-byte slot
    task automatic run_prom_burst();
        prog_port_t         saved;
        logic [PROM_AW-1:0] idx;
        logic [7:0]         data;
        saved = prog;
        for (int i = 0; i < N_PROM; i++) begin
            idx  = PROM_AW'(i * 16) | PROM_AW'(rand_bits(4));
            data = 8'(rand_bits(8));
            prom_model[idx] = data;
            prom_idx.push_back(idx);
            drive_byte(PROM_START + DWNLD_AW'(idx), data);
            check_value(64'(prog), 64'(saved), "prog during PROM burst");
            check_value(64'(prog_we), 64'(1'b0), "prog_we during PROM burst");
        end
        foreach (prom_idx[i]) begin
            read_prom_check(prom_idx[i]);
        end
    endtask

    // strobes with downloading low must not reach SDRAM or the PROM
    task automatic ignore_idle_writes();
        prog_port_t         saved;
        logic [PROM_AW-1:0] idx;
        saved = prog;
        idx   = prom_idx[0];
        // the PROM strobe goes first so a stray write would land before the read back
        drive_byte(PROM_START + DWNLD_AW'(idx), ~prom_model[idx]);
        drive_byte({3'b000, 2'd3, 20'(rand_bits(20))}, 8'(rand_bits(8)));
        check_value(64'(prog), 64'(saved), "prog after idle writes");
        check_value(64'(prog_we), 64'(1'b0), "prog_we after idle writes");
        read_prom_check(idx);
    endtask

    ///////////////////////////////////////////////////////////////////////
    // sequence

    always @(negedge clk) begin
        if (dwnld_done) begin
            done_count++;
        end
    end

    initial begin
        downloading  = 1'b0;
        ioctl_addr   = '0;
        ioctl_data   = '0;
        ioctl_wr     = 1'b0;
        sdram_ack    = 1'b0;
        prom_rd_addr = '0;
        @(posedge rst_n);
        @(negedge clk);
        downloading = 1'b1;
        @(negedge clk);
        // cycle through the four banks
        for (int i = 0; i < N_SDRAM; i++) begin
            send_sdram_byte(2'(i));
        end
        reload_pending();
        run_prom_burst();
        downloading = 1'b0;
        @(negedge clk);
        ignore_idle_writes();
        // second download, cut while a request is still waiting for its ack
        downloading = 1'b1;
        @(negedge clk);
        drive_byte({3'b000, 2'd0, 20'(rand_bits(20))}, 8'(rand_bits(8)));
        check_value(64'(prog_we), 64'(1'b1), "prog_we before cut");
        downloading = 1'b0;
        @(negedge clk);
        check_value(64'(prog_we), 64'(1'b0), "prog_we after cut");
        repeat (2) @(negedge clk);
        check_value(64'(done_count), 64'(2), "dwnld_done pulse count");
        a_fails = i_dwnld_top.i_assertions.fail_count;
        $display("errors: %0d testbench checks, %0d assertion checks", errors, a_fails);
        if (errors == 0 && a_fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("watchdog expired after %0d time units, the run did not finish", TIMEOUT);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire
